// File: z80LiteCore.f
+incdir+.
z80BusPkg.sv
z80IsaPkg.sv
z80Alu.sv
z80Sequencer.sv
z80Decoder.sv
z80Datapath.sv
z80LiteCore.sv
z80LiteTb.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing
TOP      = z80LiteTb
FILELIST = z80LiteCore.f
PASS     = No errors

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with $(TOOL) and run the testbench"
	@echo "  clean  remove build output"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "$(PASS)"

clean:
	rm -rf obj_dir

// File: z80RefModel.svh
// Instruction-level model of the kept opcode subset; expects refMem loaded and stops at HALT
`ifndef Z80_REF_MODEL_SVH
`define Z80_REF_MODEL_SVH

z80BusPkg::addrT expFetch[$];      // Opcode fetch addresses in order
z80BusPkg::addrT expWrAddr[$];
z80BusPkg::dataT expWrData[$];
z80BusPkg::addrT expHaltAddr;
logic [7:0]      refMem [0:65535];

task automatic runModel();
  z80BusPkg::addrT pc;
  z80BusPkg::addrT nn;
  z80BusPkg::dataT a;
  z80BusPkg::dataT op;
  z80BusPkg::dataT n;
  logic            z;
  logic            done;
  int              steps;
  pc = z80BusPkg::resetPc;
  a = 8'h00;
  z = 1'b0;
  done = 1'b0;
  steps = 0;
  while (!done && steps < 1000)
  begin
    steps++;
    expFetch.push_back(pc);
    op = refMem[pc];
    n  = refMem[pc + 16'd1];
    nn = {refMem[pc + 16'd2], refMem[pc + 16'd1]};   // Little endian operand
    case (op)
      z80IsaPkg::opLdAN:
      begin
        a = n;
        pc = pc + 16'd2;
      end
      z80IsaPkg::opAddN:
      begin
        a = a + n;
        z = (a == 8'h00);
        pc = pc + 16'd2;
      end
      z80IsaPkg::opSubN:
      begin
        a = a - n;
        z = (a == 8'h00);
        pc = pc + 16'd2;
      end
      z80IsaPkg::opAndN:
      begin
        a = a & n;
        z = (a == 8'h00);
        pc = pc + 16'd2;
      end
      z80IsaPkg::opXorN:
      begin
        a = a ^ n;
        z = (a == 8'h00);
        pc = pc + 16'd2;
      end
      z80IsaPkg::opLdNnA:
      begin
        expWrAddr.push_back(nn);
        expWrData.push_back(a);
        refMem[nn] = a;
        pc = pc + 16'd3;
      end
      z80IsaPkg::opLdANn:
      begin
        a = refMem[nn];
        pc = pc + 16'd3;
      end
      z80IsaPkg::opJp:    pc = nn;
      z80IsaPkg::opJpZ, z80IsaPkg::opJpNz:
      begin
        if (z == (op == z80IsaPkg::opJpZ))
          pc = nn;
        else
          pc = pc + 16'd3;
      end
      z80IsaPkg::opHalt:
      begin
        expHaltAddr = pc;
        done = 1'b1;
      end
      default:            pc = pc + 16'd1;   // NOP and unknown opcodes
    endcase
  end
endtask

`endif

// File: z80LiteTb.sv
// Random program of 64 instructions with stalls; fetch, write and halt checked against a model
`timescale 1ns/1ps

module z80LiteTb;

  localparam int progLen = 64;
  localparam int haltIdx = progLen - 1;

  logic            clk;
  logic            reset_n;
  logic            cen;
  logic            wait_n;
  z80BusPkg::dataT di;
  z80BusPkg::dataT dout;
  z80BusPkg::addrT addr;
  logic            m1N, rd, write, haltN;

  logic [7:0]        mem [0:65535];
  integer            seed = 32'hc340_d4a1;
  int                errors = 0;
  int                checks = 0;
  logic              timedOut = 1'b0;
  logic              directed = 1'b1;   // Stalls held off for the NOP segment
  z80BusPkg::addrT   fetchLog[$];
  int                fetchCyc[$];
  z80BusPkg::addrT   wrAddrLog[$];
  z80BusPkg::dataT   wrDataLog[$];
  int                cycle = 0;
  int                badStrobe = 0;
  logic              prevM1 = 1'b1;
  logic              prevWrite = 1'b0;
  z80IsaPkg::opcodeT progOp [0:progLen-1];
  logic [7:0]        progImm [0:progLen-1];
  int                progTarget [0:progLen-1];
  z80BusPkg::addrT   progStart [0:progLen-1];

  `include "z80RefModel.svh"

  initial clk = 1'b0;
  always #5 clk = ~clk;

  assign di = mem[addr];   // Combinational read

  z80LiteCore dut_i
  (
    .clk     (clk),
    .reset_n (reset_n),
    .cen     (cen),
    .wait_n  (wait_n),
    .di      (di),
    .addr    (addr),
    .dout    (dout),
    .m1N     (m1N),
    .rd      (rd),
    .write   (write),
    .haltN   (haltN)
  );

  // Stall stimulus, about 20% low each
  always @(posedge clk)
  begin
    #1;
    cen    = directed || (({$random(seed)} % 5) != 0);
    wait_n = directed || (({$random(seed)} % 5) != 0);
  end

  //--------------------------------------------------------------------------
  // Bus monitor, sees the values settled by the previous edge
  //--------------------------------------------------------------------------
  always @(posedge clk)
  begin
    cycle++;
    if (reset_n && prevM1 && !m1N)
    begin
      fetchLog.push_back(addr);
      fetchCyc.push_back(cycle);
    end
    if (reset_n && write && !prevWrite)   // First edge of the write strobe
    begin
      wrAddrLog.push_back(addr);
      wrDataLog.push_back(dout);
      mem[addr] = dout;
    end
    if (write && (rd || !m1N))
      badStrobe++;
    prevM1 = m1N;
    prevWrite = write;
  end

  function automatic logic [7:0] randByte();
    int r;
    r = $random(seed);
    return r[7:0];
  endfunction

  function automatic int randBelow(int n);
    return {$random(seed)} % n;
  endfunction

  function automatic logic isJump(z80IsaPkg::opcodeT op);
    return op == z80IsaPkg::opJp || op == z80IsaPkg::opJpZ || op == z80IsaPkg::opJpNz;
  endfunction

  function automatic logic [15:0] opSize(z80IsaPkg::opcodeT op);
    if (isJump(op) || op == z80IsaPkg::opLdNnA || op == z80IsaPkg::opLdANn)
      return 16'd3;
    if (op == z80IsaPkg::opLdAN || op == z80IsaPkg::opAddN || op == z80IsaPkg::opSubN ||
        op == z80IsaPkg::opAndN || op == z80IsaPkg::opXorN)
      return 16'd2;
    return 16'd1;
  endfunction

  task automatic setInstr(int i, z80IsaPkg::opcodeT op, logic [7:0] imm, int target);
    progOp[i] = op;
    progImm[i] = imm;
    progTarget[i] = target;
  endtask

  //--------------------------------------------------------------------------
  // Program: 8 NOPs, a fixed jump preamble, random body, HALT
  //--------------------------------------------------------------------------
  task automatic buildProgram();
    int              i;
    int              k;
    z80BusPkg::addrT a16;
    z80BusPkg::addrT nn;
    for (i = 0; i < 65536; i++)
    begin
      a16 = i[15:0];
      mem[a16] = a16[7:0] ^ a16[15:8] ^ 8'h5a;
    end
    for (i = 0; i < 256; i++)
    begin
      a16 = 16'h8000 | i[15:0];
      mem[a16] = randByte();
    end
    for (i = 0; i < 8; i++)
      setInstr(i, z80IsaPkg::opNop, 8'h00, 0);
    setInstr(8, z80IsaPkg::opLdAN, 8'h00, 0);
    setInstr(9, z80IsaPkg::opAndN, 8'h00, 0);    // Z set
    setInstr(10, z80IsaPkg::opJpZ, 8'h00, 12);   // Taken
    setInstr(11, z80IsaPkg::opNop, 8'h00, 0);
    setInstr(12, z80IsaPkg::opJpNz, 8'h00, 14);  // Not taken
    setInstr(13, z80IsaPkg::opXorN, 8'h01, 0);   // Z clear
    setInstr(14, z80IsaPkg::opJpNz, 8'h00, 16);
    setInstr(15, z80IsaPkg::opNop, 8'h00, 0);
    setInstr(16, z80IsaPkg::opJpZ, 8'h00, 18);
    setInstr(17, z80IsaPkg::opJp, 8'h00, 19);
    setInstr(18, z80IsaPkg::opNop, 8'h00, 0);
    for (i = 19; i < haltIdx; i++)
    begin
      k = randBelow(9);
      case (k)
        0: progOp[i] = z80IsaPkg::opNop;
        1: progOp[i] = z80IsaPkg::opLdAN;
        2: progOp[i] = z80IsaPkg::opAddN;
        3: progOp[i] = z80IsaPkg::opSubN;
        4: progOp[i] = z80IsaPkg::opAndN;
        5: progOp[i] = z80IsaPkg::opXorN;
        6: progOp[i] = z80IsaPkg::opLdNnA;
        7: progOp[i] = z80IsaPkg::opLdANn;
        default: progOp[i] = (randBelow(3) == 0) ? z80IsaPkg::opJp :
                             (randBelow(2) == 0) ? z80IsaPkg::opJpZ : z80IsaPkg::opJpNz;
      endcase
      progImm[i] = randByte();
      progTarget[i] = i + 1 + randBelow(3);
      if (progTarget[i] > haltIdx)
        progTarget[i] = haltIdx;
    end
    setInstr(haltIdx, z80IsaPkg::opHalt, 8'h00, 0);
    a16 = z80BusPkg::resetPc;
    for (i = 0; i < progLen; i++)
    begin
      progStart[i] = a16;
      a16 = a16 + opSize(progOp[i]);
    end
    for (i = 0; i < progLen; i++)
    begin
      a16 = progStart[i];
      mem[a16] = progOp[i];
      if (opSize(progOp[i]) == 16'd2)
        mem[a16 + 16'd1] = progImm[i];
      if (opSize(progOp[i]) == 16'd3)
      begin
        nn = isJump(progOp[i]) ? progStart[progTarget[i]] : {8'h80, progImm[i]};
        mem[a16 + 16'd1] = nn[7:0];
        mem[a16 + 16'd2] = nn[15:8];
      end
    end
    for (i = 0; i < 65536; i++)
      refMem[i] = mem[i];
  endtask

  task automatic flagTimeout(string what);
    timedOut = 1'b1;
    errors++;
    $display("Timeout while waiting for %s", what);
  endtask

  task automatic waitFetches(int count, int limit, string what);
    int n;
    n = 0;
    while (fetchLog.size() < count && n < limit)
    begin
      @(posedge clk);
      #2;
      n++;
    end
    if (fetchLog.size() < count)
      flagTimeout(what);
  endtask

  task automatic waitHalt(int limit);
    int n;
    n = 0;
    while (haltN !== 1'b0 && n < limit)
    begin
      @(posedge clk);
      #2;
      n++;
    end
    if (haltN !== 1'b0)
      flagTimeout("haltN to go low");
  endtask

  task automatic reportTest(string name, int errsBefore);
    $display("Test %s: %s", name, (errors == errsBefore) ? "pass" : "FAIL");
  endtask

  //--------------------------------------------------------------------------
  // Main sequence
  //--------------------------------------------------------------------------
  initial
  begin
    int i;
    int e0;
    int nf;
    reset_n = 1'b0;
    cen = 1'b1;
    wait_n = 1'b1;
    buildProgram();
    runModel();
    repeat (2) @(posedge clk);
    #1;
    e0 = errors;
    checks++;
    if (m1N !== 1'b1 || rd !== 1'b0 || write !== 1'b0 || haltN !== 1'b1)
    begin
      errors++;
      $display("Error at %0t: reset outputs expected m1N rd write haltN 1001, got %b%b%b%b",
               $time, m1N, rd, write, haltN);
    end
    reset_n = 1'b1;
    waitFetches(9, 200, "the NOP segment fetches");
    if (!timedOut)
    begin
      checks++;
      if (fetchLog[0] !== z80BusPkg::resetPc)
      begin
        errors++;
        $display("Error at %0t: first fetch expected %h, got %h", $time,
                 z80BusPkg::resetPc, fetchLog[0]);
      end
      reportTest("1 reset", e0);

      e0 = errors;
      // The first m1N edge lags its T1 by one cycle after reset
      for (i = 2; i < 9; i++)
      begin
        checks++;
        if (fetchCyc[i] - fetchCyc[i-1] != 4)
        begin
          errors++;
          $display("Error at %0t: fetch spacing expected 4, got %0d", $time,
                   fetchCyc[i] - fetchCyc[i-1]);
        end
      end
      directed = 1'b0;
      reportTest("5 fixed timing", e0);

      waitHalt(20000);
    end
    if (!timedOut)
    begin
      nf = expFetch.size();
      waitFetches(nf + 3, 400, "fetches after HALT");
    end

    if (!timedOut)
    begin
      e0 = errors;
      for (i = 0; i < nf; i++)
      begin
        checks++;
        if (fetchLog[i] !== expFetch[i])
        begin
          errors++;
          $display("Error at %0t: fetch %0d expected %h, got %h", $time, i,
                   expFetch[i], fetchLog[i]);
        end
      end
      reportTest("3 control flow", e0);

      e0 = errors;
      checks++;
      if (wrAddrLog.size() != expWrAddr.size())
      begin
        errors++;
        $display("Error at %0t: write count expected %0d, got %0d", $time,
                 expWrAddr.size(), wrAddrLog.size());
      end
      for (i = 0; i < wrAddrLog.size() && i < expWrAddr.size(); i++)
      begin
        checks++;
        if (wrAddrLog[i] !== expWrAddr[i] || wrDataLog[i] !== expWrData[i])
        begin
          errors++;
          $display("Error at %0t: write %0d expected %h=%h, got %h=%h", $time, i,
                   expWrAddr[i], expWrData[i], wrAddrLog[i], wrDataLog[i]);
        end
      end
      reportTest("2 arithmetic and loads", e0);

      e0 = errors;
      checks++;
      if (badStrobe != 0)
      begin
        errors++;
        $display("Write strobe was seen together with rd or m1N low %0d times", badStrobe);
      end
      reportTest("4 stalls", e0);

      e0 = errors;
      for (i = nf; i < nf + 3; i++)
      begin
        checks++;
        if (fetchLog[i] !== expHaltAddr + 16'd1)
        begin
          errors++;
          $display("Error at %0t: halted fetch expected %h, got %h", $time,
                   expHaltAddr + 16'd1, fetchLog[i]);
        end
      end
      checks++;
      if (haltN !== 1'b0 || wrAddrLog.size() != expWrAddr.size())
      begin
        errors++;
        $display("Core left HALT or wrote memory while halted");
      end
      reportTest("6 halt", e0);
    end

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("No errors");
    else
      $display("Errors found");
    $finish;
  end

endmodule

// File: z80LiteCore.sv
// Memory-only Z80 subset core; no interrupts, bus request, refresh or I/O cycles
`timescale 1ns/1ps

module z80LiteCore
(
  input  logic             clk,
  input  logic             reset_n,
  input  logic             cen,
  input  logic             wait_n,
  input  z80BusPkg::dataT  di,
  output z80BusPkg::addrT  addr,
  output z80BusPkg::dataT  dout,
  output logic             m1N,
  output logic             rd,
  output logic             write,
  output logic             haltN
);

  z80BusPkg::tStateT  tState;
  z80BusPkg::mCycleT  mCycle;
  z80IsaPkg::opcodeT  ir;
  z80IsaPkg::addrSelT addrSel;
  z80IsaPkg::aluOpT   aluOp;
  logic               tick, zeroFlag;
  logic               lastCycle, memRead, memWrite;
  logic               loadOperandLow, loadOperandHigh;
  logic               loadAcc, jumpTaken, isHalt;

  z80Sequencer seq_i
  (
    .clk       (clk),
    .reset_n   (reset_n),
    .cen       (cen),
    .wait_n    (wait_n),
    .lastCycle (lastCycle),
    .memRead   (memRead),
    .memWrite  (memWrite),
    .tState    (tState),
    .mCycle    (mCycle),
    .tick      (tick),
    .m1N       (m1N),
    .rd        (rd),
    .write     (write)
  );

  z80Decoder dec_i
  (
    .ir              (ir),
    .mCycle          (mCycle),
    .zeroFlag        (zeroFlag),
    .lastCycle       (lastCycle),
    .memRead         (memRead),
    .memWrite        (memWrite),
    .addrSel         (addrSel),
    .loadOperandLow  (loadOperandLow),
    .loadOperandHigh (loadOperandHigh),
    .aluOp           (aluOp),
    .loadAcc         (loadAcc),
    .jumpTaken       (jumpTaken),
    .isHalt          (isHalt)
  );

  z80Datapath dp_i
  (
    .clk             (clk),
    .reset_n         (reset_n),
    .tick            (tick),
    .tState          (tState),
    .mCycle          (mCycle),
    .di              (di),
    .addrSel         (addrSel),
    .loadOperandLow  (loadOperandLow),
    .loadOperandHigh (loadOperandHigh),
    .aluOp           (aluOp),
    .loadAcc         (loadAcc),
    .jumpTaken       (jumpTaken),
    .isHalt          (isHalt),
    .ir              (ir),
    .zeroFlag        (zeroFlag),
    .addr            (addr),
    .dout            (dout),
    .haltN           (haltN)
  );

endmodule

// File: z80Datapath.sv
// PC, IR, WZ-style temp address, A and F; HALT is left only through reset
`timescale 1ns/1ps

module z80Datapath
(
  input  logic                clk,
  input  logic                reset_n,
  input  logic                tick,
  input  z80BusPkg::tStateT   tState,
  input  z80BusPkg::mCycleT   mCycle,
  input  z80BusPkg::dataT     di,
  input  z80IsaPkg::addrSelT  addrSel,
  input  logic                loadOperandLow,
  input  logic                loadOperandHigh,
  input  z80IsaPkg::aluOpT    aluOp,
  input  logic                loadAcc,
  input  logic                jumpTaken,
  input  logic                isHalt,
  output z80IsaPkg::opcodeT   ir,
  output logic                zeroFlag,
  output z80BusPkg::addrT     addr,
  output z80BusPkg::dataT     dout,
  output logic                haltN
);

  z80BusPkg::addrT pc, pcNext;
  z80BusPkg::addrT tmp, tmpNext;
  z80BusPkg::dataT acc, flags;
  z80BusPkg::dataT aluResult;
  logic            aluZero, aluCarry;
  logic            capture;   // Edge that ends T3, di is sampled here
  logic            enterT1;   // Edge that starts the next M-cycle

  assign capture  = tick && (tState == z80BusPkg::T3);
  assign enterT1  = tick && ((mCycle == z80BusPkg::M1) ? (tState == z80BusPkg::T4)
                                                       : (tState == z80BusPkg::T3));
  assign zeroFlag = flags[z80IsaPkg::flagZ];

  // Operand byte on di feeds the ALU directly
  z80Alu alu_i
  (
    .aluOp  (aluOp),
    .a      (acc),
    .b      (di),
    .result (aluResult),
    .zero   (aluZero),
    .carry  (aluCarry)
  );

  //--------------------------------------------------------------------------
  // PC and temp address, next values seen by the address register
  //--------------------------------------------------------------------------
  always_comb
  begin
    pcNext  = pc;
    tmpNext = tmp;
    if (capture)
    begin
      if (loadOperandLow)
        tmpNext[7:0] = di;            // Low byte arrives first
      if (loadOperandHigh)
        tmpNext[15:8] = di;
      if (jumpTaken)
        pcNext = tmpNext;
      else if ((mCycle == z80BusPkg::M1 && haltN) || loadOperandLow || loadOperandHigh)
        pcNext = pc + 16'd1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (!reset_n)
    begin
      pc    <= z80BusPkg::resetPc;
      addr  <= z80BusPkg::resetPc;
      ir    <= z80IsaPkg::opNop;
      acc   <= '0;
      flags <= '0;
      haltN <= 1'b1;
    end
    else
    begin
      pc <= pcNext;
      if (capture && mCycle == z80BusPkg::M1)
        ir <= haltN ? di : z80IsaPkg::opNop;   // Halted core keeps fetching NOPs
      if (capture && loadAcc)
      begin
        acc <= aluResult;
        // Loads leave F alone, as on a Z80
        if (aluOp != z80IsaPkg::aluPass)
        begin
          flags[z80IsaPkg::flagZ] <= aluZero;
          flags[z80IsaPkg::flagC] <= aluCarry;
        end
      end
      if (enterT1)
        addr <= (addrSel == z80IsaPkg::selTmp) ? tmpNext : pcNext;
      if (enterT1 && mCycle == z80BusPkg::M1 && isHalt)
        haltN <= 1'b0;
    end
  end

  // Operand bytes and write data
  always_ff @(posedge clk)
  begin
    tmp <= tmpNext;
    if (enterT1)
      dout <= acc;   // Valid from T1 of the write cycle
  end

endmodule

// File: z80Decoder.sv
// Microcode for the kept opcode subset only; outputs in M1 before T4 reflect the previous opcode
`timescale 1ns/1ps

module z80Decoder
(
  input  z80IsaPkg::opcodeT   ir,
  input  z80BusPkg::mCycleT   mCycle,
  input  logic                zeroFlag,
  output logic                lastCycle,
  output logic                memRead,
  output logic                memWrite,
  output z80IsaPkg::addrSelT  addrSel,
  output logic                loadOperandLow,
  output logic                loadOperandHigh,
  output z80IsaPkg::aluOpT    aluOp,
  output logic                loadAcc,
  output logic                jumpTaken,
  output logic                isHalt
);

  logic condMet;

  // JP nn always, the conditional forms test Z
  assign condMet = (ir == z80IsaPkg::opJp) ||
                   (ir == z80IsaPkg::opJpZ && zeroFlag) ||
                   (ir == z80IsaPkg::opJpNz && !zeroFlag);

  always_comb
  begin
    lastCycle       = 1'b0;
    memRead         = 1'b1;            // Every cycle reads unless told otherwise
    memWrite        = 1'b0;
    addrSel         = z80IsaPkg::selPc;
    loadOperandLow  = 1'b0;
    loadOperandHigh = 1'b0;
    loadAcc         = 1'b0;
    jumpTaken       = 1'b0;
    isHalt          = 1'b0;

    case (ir)
      z80IsaPkg::opLdAN, z80IsaPkg::opAddN, z80IsaPkg::opSubN,
      z80IsaPkg::opAndN, z80IsaPkg::opXorN:
      begin
        if (mCycle == z80BusPkg::M2)   // Immediate byte goes straight to the ALU
        begin
          loadOperandLow = 1'b1;
          loadAcc        = 1'b1;
          lastCycle      = 1'b1;
        end
      end
      z80IsaPkg::opJp, z80IsaPkg::opJpZ, z80IsaPkg::opJpNz:
      begin
        loadOperandLow = (mCycle == z80BusPkg::M2);
        if (mCycle == z80BusPkg::M3)
        begin
          loadOperandHigh = 1'b1;
          lastCycle       = 1'b1;
          jumpTaken       = condMet;
        end
      end
      z80IsaPkg::opLdNnA, z80IsaPkg::opLdANn:
      begin
        loadOperandLow = (mCycle == z80BusPkg::M2);
        if (mCycle == z80BusPkg::M3)
        begin
          loadOperandHigh = 1'b1;
          addrSel         = z80IsaPkg::selTmp;   // Data cycle follows at nn
        end
        if (mCycle == z80BusPkg::M4)
        begin
          lastCycle = 1'b1;
          memRead   = (ir == z80IsaPkg::opLdANn);
          memWrite  = (ir == z80IsaPkg::opLdNnA);
          loadAcc   = (ir == z80IsaPkg::opLdANn);
        end
      end
      z80IsaPkg::opHalt:
      begin
        lastCycle = 1'b1;
        isHalt    = (mCycle == z80BusPkg::M1);
      end
      default: lastCycle = 1'b1;       // NOP and everything unknown
    endcase
  end

  // ALU function, loads pass di through
  always_comb
  begin
    case (ir)
      z80IsaPkg::opAddN: aluOp = z80IsaPkg::aluAdd;
      z80IsaPkg::opSubN: aluOp = z80IsaPkg::aluSub;
      z80IsaPkg::opAndN: aluOp = z80IsaPkg::aluAnd;
      z80IsaPkg::opXorN: aluOp = z80IsaPkg::aluXor;
      default:           aluOp = z80IsaPkg::aluPass;
    endcase
  end

endmodule

// File: z80Sequencer.sv
// T2 stretches only through wait_n, no auto-wait states; strobes inactive in the first T1 after reset
`timescale 1ns/1ps

module z80Sequencer
(
  input  logic               clk,
  input  logic               reset_n,
  input  logic               cen,
  input  logic               wait_n,
  input  logic               lastCycle,
  input  logic               memRead,
  input  logic               memWrite,
  output z80BusPkg::tStateT  tState,
  output z80BusPkg::mCycleT  mCycle,
  output logic               tick,
  output logic               m1N,
  output logic               rd,
  output logic               write
);

  z80BusPkg::tStateT nextT;
  z80BusPkg::mCycleT nextM;
  logic              finalT;     // Last T-state of the current M-cycle
  logic              busActive;  // Registered T1 to T3 window

  // Opcode fetch has a fourth T-state, all other cycles end at T3
  assign finalT = (mCycle == z80BusPkg::M1) ? (tState == z80BusPkg::T4)
                                            : (tState == z80BusPkg::T3);

  // Hold everything while disabled or while T2 is being stretched
  assign tick = cen && !(tState == z80BusPkg::T2 && !wait_n);

  //--------------------------------------------------------------------------
  // Next state
  //--------------------------------------------------------------------------
  always_comb
  begin
    nextT = tState;
    nextM = mCycle;
    if (finalT)
    begin
      nextT = z80BusPkg::T1;
      if (lastCycle)
        nextM = z80BusPkg::M1;
      else
        nextM = z80BusPkg::mCycleT'(mCycle + 2'd1);
    end
    else
    begin
      nextT = z80BusPkg::tStateT'(tState + 2'd1);
    end
  end

  //--------------------------------------------------------------------------
  // State and strobe registers
  //--------------------------------------------------------------------------
  always_ff @(posedge clk)
  begin
    if (!reset_n)
    begin
      tState    <= z80BusPkg::T1;
      mCycle    <= z80BusPkg::M1;
      m1N       <= 1'b1;
      busActive <= 1'b0;
      write     <= 1'b0;
    end
    else if (tick)
    begin
      tState    <= nextT;
      mCycle    <= nextM;
      m1N       <= !(nextM == z80BusPkg::M1 && nextT != z80BusPkg::T4);
      busActive <= (nextT != z80BusPkg::T4);
      // Write strobe covers T2 and T3 only, dout is already stable
      write     <= memWrite && (nextT == z80BusPkg::T2 || nextT == z80BusPkg::T3);
    end
  end

  // memRead already belongs to the new cycle once mCycle has stepped
  assign rd = busActive && memRead;

endmodule

// File: z80Alu.sv
// 8-bit ALU with Z and C only; no half carry, parity or sign, borrow reported as carry
`timescale 1ns/1ps

module z80Alu
(
  input  z80IsaPkg::aluOpT  aluOp,
  input  z80BusPkg::dataT   a,
  input  z80BusPkg::dataT   b,
  output z80BusPkg::dataT   result,
  output logic              zero,
  output logic              carry
);

  logic [8:0] wide;   // Result with carry out in bit 8

  always_comb
  begin
    case (aluOp)
      z80IsaPkg::aluAdd: wide = {1'b0, a} + {1'b0, b};
      z80IsaPkg::aluSub: wide = {1'b0, a} - {1'b0, b};   // Bit 8 set on borrow
      z80IsaPkg::aluAnd: wide = {1'b0, a & b};
      z80IsaPkg::aluXor: wide = {1'b0, a ^ b};
      default:           wide = {1'b0, b};
    endcase
  end

  assign result = wide[7:0];
  assign zero   = (wide[7:0] == 8'h00);
  assign carry  = wide[8];

endmodule

// File: z80IsaPkg.sv
// Opcode subset and ALU encodings; any opcode not listed here runs as NOP
package z80IsaPkg;

  typedef logic [7:0] opcodeT;

  //--------------------------------------------------------------------------
  // Opcodes, standard Z80 encodings
  //--------------------------------------------------------------------------
  localparam opcodeT opNop   = 8'h00;
  localparam opcodeT opLdAN  = 8'h3E;   // LD A,n
  localparam opcodeT opAddN  = 8'hC6;   // ADD A,n
  localparam opcodeT opSubN  = 8'hD6;
  localparam opcodeT opAndN  = 8'hE6;
  localparam opcodeT opXorN  = 8'hEE;
  localparam opcodeT opLdNnA = 8'h32;   // LD (nn),A
  localparam opcodeT opLdANn = 8'h3A;   // LD A,(nn)
  localparam opcodeT opJp    = 8'hC3;
  localparam opcodeT opJpZ   = 8'hCA;
  localparam opcodeT opJpNz  = 8'hC2;
  localparam opcodeT opHalt  = 8'h76;

  // Bit positions in F, the remaining flag bits stay zero
  localparam int flagZ = 6;
  localparam int flagC = 0;

  typedef enum logic [2:0]
  {
    aluPass,
    aluAdd,
    aluSub,
    aluAnd,
    aluXor
  } aluOpT;

  // Source of the address for the next machine cycle
  typedef enum logic
  {
    selPc,
    selTmp
  } addrSelT;

endpackage

// File: z80BusPkg.sv
// Bus widths and sequencer states; 16-bit address and 8-bit data only, no I/O space
package z80BusPkg;

  //--------------------------------------------------------------------------
  // Bus widths
  //--------------------------------------------------------------------------
  typedef logic [15:0] addrT;   // Memory address
  typedef logic [7:0]  dataT;   // Data byte

  // Clock phase inside a machine cycle
  typedef enum logic [1:0]
  {
    T1,
    T2,
    T3,
    T4
  } tStateT;

  // Machine cycle index within an instruction, four at most
  typedef enum logic [1:0]
  {
    M1,
    M2,
    M3,
    M4
  } mCycleT;

  // First opcode fetch after reset
  localparam addrT resetPc = 16'h0000;

endpackage
